// File: verilog/dbg_wb_pkg.sv
// JTAG to Wishbone debug module, shared definitions
// Opcodes, data register layout, FSM states and CRC-32 constants
package dbg_wb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command opcodes, field 51:48 of the data register
  localparam logic [3:0] CMD_BWRITE32 = 4'd3;  // Burst write of 32-bit words
  localparam logic [3:0] CMD_BREAD32  = 4'd7;  // Burst read of 32-bit words
  localparam logic [3:0] CMD_IREG_WR  = 4'd9;  // Internal register write

  ////////////////////////////////////////////////////////////////////////////
  // Data register layout
  localparam int DR_W       = 53;  // Full data register
  localparam int DR_MSB     = 52;  // Command flag, 0 means this module
  localparam int OP_LSB     = 48;  // Opcode field 51:48
  localparam int ADDR_LSB   = 16;  // Address field 47:16
  localparam int COUNT_LSB  = 0;   // Word count field 15:0
  localparam int DR_CLR_BIT = 46;  // Error clear bit of an ireg write

  // Widths
  localparam int WORD_W   = 32;  // Bus data word
  localparam int BITCNT_W = 6;   // Must reach 32 for the CRC phase
  localparam int CNT_W    = 16;  // Words per burst

  // Reflected CRC-32, no final inversion
  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;
  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM states
  typedef enum logic [3:0] {
    st_idle, st_rbegin, st_rready, st_rstatus, st_rburst, st_rcrc,
    st_wready, st_wwait, st_wburst, st_wcrc, st_wmatch
  } ctrl_state_t;

  // Source of module_tdo_o
  typedef enum logic [1:0] {
    tdo_ready = 2'd0,  // Bus unit ready bit
    tdo_data  = 2'd1,  // Output shift register LSB
    tdo_match = 2'd2,  // Write CRC compare result
    tdo_crc   = 2'd3   // Read CRC, serial
  } tdo_sel_t;

endpackage

// File: verilog/dbg_crc32.sv
// Serial CRC-32 for burst data
// One bit per enable, and the register doubles as its own output shifter
`timescale 1ns/10ps

module dbg_crc32 import dbg_wb_pkg::*; (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              en_i,     // Fold bit_i into the CRC
  input  logic              shift_i,  // Shift out one bit
  input  logic              clr_i,    // Back to the start value
  input  logic              bit_i,
  output logic [WORD_W-1:0] crc_o,
  output logic              serial_o
);

  logic [WORD_W-1:0] crc_q;
  logic              fb;     // Feedback, new bit against old LSB

  assign fb = bit_i ^ crc_q[0];

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= CRC_INIT;
    end else if (clr_i) begin
      crc_q <= CRC_INIT;  // Start of a new burst
    end else if (en_i) begin
      // Shift right, then apply the polynomial when the feedback is set
      crc_q <= {1'b0, crc_q[WORD_W-1:1]} ^ (fb ? CRC_POLY : '0);
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[WORD_W-1:1]};  // Zero fill toward the MSB
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];  // LSB goes out first

endmodule

// File: verilog/dbg_wb_master.sv
// Wishbone bus interface unit for the debug module
// Takes one request per strobe and runs a single classic cycle on tck_i
`timescale 1ns/10ps

module dbg_wb_master import dbg_wb_pkg::*; (
  input  logic              tck_i,
  input  logic              rst_i,     // Also pulsed by the controller to drop err
  input  logic              strobe_i,  // Latch a new request
  input  logic              rd_i,      // 1 = read, 0 = write
  input  logic [WORD_W-1:0] addr_i,
  input  logic [WORD_W-1:0] wdata_i,
  output logic [WORD_W-1:0] rdata_o,
  output logic              rdy_o,     // Last access finished
  output logic              err_o,     // Sticky bus error

  // Wishbone master
  output logic [WORD_W-1:0] wb_adr_o,
  output logic [WORD_W-1:0] wb_dat_o,
  input  logic [WORD_W-1:0] wb_dat_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  input  logic              wb_ack_i,
  input  logic              wb_err_i
);

  logic              cyc_q;
  logic              we_q;
  logic              rdy_q;
  logic              err_q;
  logic [WORD_W-1:0] adr_q;
  logic [WORD_W-1:0] dat_q;
  logic [WORD_W-1:0] rdata_q;
  logic              done;

  assign done = cyc_q & (wb_ack_i | wb_err_i);  // Slave ends the cycle

  ////////////////////////////////////////////////////////////////////////////
  // Cycle control
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      cyc_q <= 1'b0;
      we_q  <= 1'b0;
      rdy_q <= 1'b1;  // Idle unit counts as ready
      err_q <= 1'b0;
    end else if (strobe_i) begin
      cyc_q <= 1'b1;
      we_q  <= ~rd_i;
      rdy_q <= 1'b0;
    end else if (done) begin
      cyc_q <= 1'b0;
      we_q  <= 1'b0;
      rdy_q <= 1'b1;
      if (wb_err_i) begin
        err_q <= 1'b1;  // Held until the next reset
      end
    end
  end

  // Request and read data
  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      adr_q <= addr_i;
      dat_q <= wdata_i;
    end
    if (done && wb_ack_i && !we_q) begin
      rdata_q <= wb_dat_i;
    end
  end

  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;  // Classic cycle, stb follows cyc
  assign wb_we_o  = we_q;
  assign rdata_o  = rdata_q;
  assign rdy_o    = rdy_q;
  assign err_o    = err_q;

endmodule

// File: verilog/dbg_wb_error_reg.sv
// Bus error register
// Tracks the address of each access and traps the first one that fails
`timescale 1ns/10ps

module dbg_wb_error_reg import dbg_wb_pkg::*; (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              check_i,    // Sample the status of the last access
  input  logic              clr_i,      // Internal register write
  input  logic              clr_bit_i,  // Write data, 1 clears the flag
  input  logic              strobe_i,   // New bus access starts
  input  logic [WORD_W-1:0] addr_i,
  input  logic              rdy_i,
  input  logic              err_i,
  output logic [WORD_W:0]   err_reg_o   // {address, flag}
);

  logic [WORD_W-1:0] addr_q;
  logic              flag_q;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q <= '0;
      flag_q <= 1'b0;
    end else if (clr_i) begin
      if (clr_bit_i) begin
        flag_q <= 1'b0;  // Address stays for inspection
      end
    end else if (!flag_q) begin
      // An unfinished access counts as a failure too
      if (check_i && (err_i || !rdy_i)) begin
        flag_q <= 1'b1;
      end else if (strobe_i) begin
        addr_q <= addr_i;  // Freezes once the flag is up
      end
    end
  end

  assign err_reg_o = {addr_q, flag_q};

endmodule

// File: verilog/dbg_wb_ctrl.sv
// Debug module controller
// Decodes TAP commands, sequences burst reads and writes, and drives TDO
`timescale 1ns/10ps

module dbg_wb_ctrl import dbg_wb_pkg::*; (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              tdi_i,
  input  logic              capture_dr_i,
  input  logic              shift_dr_i,
  input  logic              update_dr_i,
  input  logic              module_select_i,
  input  logic [DR_W-1:0]   data_register_i,
  input  logic              biu_rdy_i,
  input  logic              biu_err_i,
  input  logic [WORD_W-1:0] biu_rdata_i,
  input  logic [WORD_W-1:0] crc_i,
  input  logic              crc_serial_i,
  input  logic [WORD_W:0]   err_reg_i,
  output logic              biu_strobe_o,
  output logic              biu_rd_o,
  output logic [WORD_W-1:0] biu_addr_o,
  output logic [WORD_W-1:0] biu_wdata_o,
  output logic              biu_clr_o,     // Reset of the bus unit
  output logic              crc_en_o,
  output logic              crc_shift_o,
  output logic              crc_clr_o,
  output logic              crc_bit_o,
  output logic              err_check_o,
  output logic              err_clr_o,
  output logic              module_tdo_o,
  output logic              top_inhibit_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Registers and FSM strobes
  ctrl_state_t       state_q, state_d;
  tdo_sel_t          tdo_sel;
  logic [3:0]        opcode_q;
  logic [WORD_W-1:0] addr_q;                // Next bus address
  logic [CNT_W-1:0]  word_cnt_q;            // Words still to go
  logic [BITCNT_W-1:0] bit_cnt_q;           // Bits of the current word
  logic [WORD_W:0]   out_q;                 // Wide enough for the error register
  logic              clr_q;
  logic              addr_ld, op_ld, word_ld, word_dec, bit_inc, bit_clr;
  logic              out_ld, out_shift, load_next, clr_err;

  // Command fields, straight from the data register
  logic [3:0]        op_in;
  logic              cmd_valid, burst_cmd, rd_op;
  logic              word_zero, word_dec_zero, bit_max, bit_32, crc_match;

  assign op_in     = data_register_i[OP_LSB +: 4];
  assign cmd_valid = module_select_i & update_dr_i & ~data_register_i[DR_MSB];
  assign burst_cmd = (op_in == CMD_BWRITE32) || (op_in == CMD_BREAD32);
  assign rd_op     = (opcode_q == CMD_BREAD32);

  assign word_zero     = (word_cnt_q == '0);
  assign word_dec_zero = (word_cnt_q == CNT_W'(1));  // Decrement would reach zero
  assign bit_max       = (bit_cnt_q == BITCNT_W'(WORD_W - 1));
  assign bit_32        = (bit_cnt_q == BITCNT_W'(WORD_W));

  // CRC sent by the debugger sits in 52:21 after 32 shifts
  assign crc_match = (data_register_i[DR_MSB -: WORD_W] == crc_i);

  ////////////////////////////////////////////////////////////////////////////
  // Counters and latches
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      opcode_q   <= '0;
      addr_q     <= '0;
      word_cnt_q <= '0;
      bit_cnt_q  <= '0;
      out_q      <= '0;
      clr_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      clr_q   <= clr_err;  // Registered so the bus unit reset is glitch free
      if (op_ld) opcode_q <= op_in;
      if (addr_ld) begin
        addr_q <= data_register_i[ADDR_LSB +: WORD_W];
      end else if (biu_strobe_o) begin
        addr_q <= addr_q + WORD_W'(4);  // Word steps only
      end
      if (word_ld) begin
        word_cnt_q <= data_register_i[COUNT_LSB +: CNT_W];
      end else if (word_dec) begin
        word_cnt_q <= word_cnt_q - CNT_W'(1);
      end
      if (bit_clr) begin
        bit_cnt_q <= '0;
      end else if (bit_inc) begin
        bit_cnt_q <= bit_cnt_q + BITCNT_W'(1);
      end
      if (out_ld) begin
        // Failed reads shift out zeros
        out_q <= load_next ? {1'b0, (biu_err_i ? '0 : biu_rdata_i)} : err_reg_i;
      end else if (out_shift) begin
        out_q <= {1'b0, out_q[WORD_W:1]};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM, next state and strobes
  always_comb begin
    state_d       = state_q;
    tdo_sel       = tdo_data;
    top_inhibit_o = 1'b0;
    {addr_ld, op_ld, word_ld, word_dec, bit_inc, bit_clr} = '0;
    {out_ld, out_shift, load_next, clr_err} = '0;
    {biu_strobe_o, crc_en_o, crc_shift_o, crc_clr_o, err_check_o, err_clr_o} = '0;
    case (state_q)
      st_idle: begin
        // Internal register access stays in idle
        if (module_select_i && capture_dr_i) out_ld = 1'b1;
        if (module_select_i && shift_dr_i) out_shift = 1'b1;
        if (cmd_valid && op_in == CMD_IREG_WR) err_clr_o = 1'b1;
        if (cmd_valid && burst_cmd) begin
          {addr_ld, op_ld, word_ld, bit_clr, crc_clr_o} = '1;
          state_d = (op_in == CMD_BREAD32) ? st_rbegin : st_wready;
        end
      end
      st_rbegin: begin
        if (word_zero) begin
          state_d = st_idle;  // Empty burst
        end else begin
          biu_strobe_o = 1'b1;  // Prefetch the first word
          state_d      = st_rready;
        end
      end
      st_rready: if (module_select_i && capture_dr_i) state_d = st_rstatus;
      st_rstatus: begin
        tdo_sel       = tdo_ready;  // Debugger polls this bit
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (shift_dr_i && biu_rdy_i) begin
          load_next = 1'b1;
          state_d   = st_rburst;
        end
      end
      st_rburst: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (shift_dr_i) begin
          {out_shift, bit_inc, crc_en_o} = '1;
          if (bit_max && word_zero) state_d = st_rcrc;
          else if (bit_max) load_next = 1'b1;
        end
      end
      st_rcrc: begin
        tdo_sel       = tdo_crc;
        top_inhibit_o = 1'b1;
        crc_shift_o   = shift_dr_i;
        if (update_dr_i) state_d = st_idle;  // Waits here for the end of the scan
      end
      st_wready: begin
        if (word_zero) state_d = st_idle;
        else if (module_select_i && capture_dr_i) state_d = st_wwait;
      end
      st_wwait: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (module_select_i && shift_dr_i && data_register_i[DR_MSB]) begin
          // Start bit is in, first data bit is on tdi now
          {clr_err, bit_inc, word_dec, crc_en_o} = '1;
          state_d = st_wburst;
        end
      end
      st_wburst: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (shift_dr_i) begin
          {bit_inc, crc_en_o} = '1;
          if (bit_max) begin
            {err_check_o, bit_clr, biu_strobe_o} = '1;  // Status of the word before
            if (word_zero) state_d = st_wcrc;
            else word_dec = 1'b1;
          end
        end
      end
      st_wcrc: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (bit_32) begin
          tdo_sel = tdo_match;
          state_d = st_wmatch;
        end else if (shift_dr_i) begin
          bit_inc = 1'b1;
        end
      end
      st_wmatch: begin
        tdo_sel       = tdo_match;
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          err_check_o = 1'b1;  // Last write of the burst
          state_d     = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
    // Fetch the next read word and queue the one after
    if (load_next) begin
      {err_check_o, out_ld, bit_clr, word_dec} = '1;
      biu_strobe_o = !word_dec_zero && !word_zero;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  assign biu_rd_o    = rd_op;
  assign biu_addr_o  = addr_q;
  assign biu_wdata_o = {tdi_i, data_register_i[DR_MSB -: WORD_W-1]};  // 32nd bit still on tdi
  assign biu_clr_o   = rst_i | clr_q;
  assign crc_bit_o   = rd_op ? out_q[0] : tdi_i;  // Read data or write data

  always_comb begin
    case (tdo_sel)
      tdo_ready: module_tdo_o = biu_rdy_i;
      tdo_match: module_tdo_o = crc_match;
      tdo_crc:   module_tdo_o = crc_serial_i;
      default:   module_tdo_o = out_q[0];
    endcase
  end

endmodule

// File: verilog/dbg_wb_module.sv
// JTAG debug module with Wishbone master access
// Connects the controller, bus unit, CRC and bus error register
`timescale 1ns/10ps

module dbg_wb_module import dbg_wb_pkg::*; (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              tdi_i,
  input  logic              capture_dr_i,
  input  logic              shift_dr_i,
  input  logic              update_dr_i,
  input  logic              module_select_i,
  input  logic [DR_W-1:0]   data_register_i,
  output logic              module_tdo_o,
  output logic              top_inhibit_o,
  output logic [WORD_W-1:0] wb_adr_o,
  output logic [WORD_W-1:0] wb_dat_o,
  input  logic [WORD_W-1:0] wb_dat_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  input  logic              wb_ack_i,
  input  logic              wb_err_i
);

  logic              biu_strobe, biu_rd, biu_clr, biu_rdy, biu_err;
  logic [WORD_W-1:0] biu_addr, biu_wdata, biu_rdata;
  logic              crc_en, crc_shift, crc_clr, crc_bit, crc_serial;
  logic [WORD_W-1:0] crc;
  logic              err_check, err_clr;
  logic [WORD_W:0]   err_reg;

  dbg_wb_ctrl u_ctrl (
    .tck_i, .rst_i, .tdi_i, .capture_dr_i, .shift_dr_i, .update_dr_i,
    .module_select_i, .data_register_i,
    .biu_rdy_i(biu_rdy), .biu_err_i(biu_err), .biu_rdata_i(biu_rdata),
    .crc_i(crc), .crc_serial_i(crc_serial), .err_reg_i(err_reg),
    .biu_strobe_o(biu_strobe), .biu_rd_o(biu_rd), .biu_addr_o(biu_addr),
    .biu_wdata_o(biu_wdata), .biu_clr_o(biu_clr),
    .crc_en_o(crc_en), .crc_shift_o(crc_shift), .crc_clr_o(crc_clr), .crc_bit_o(crc_bit),
    .err_check_o(err_check), .err_clr_o(err_clr),
    .module_tdo_o, .top_inhibit_o
  );

  // Bus unit runs off the controller's combined reset
  dbg_wb_master u_master (
    .tck_i, .rst_i(biu_clr), .strobe_i(biu_strobe), .rd_i(biu_rd),
    .addr_i(biu_addr), .wdata_i(biu_wdata), .rdata_o(biu_rdata),
    .rdy_o(biu_rdy), .err_o(biu_err),
    .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_cyc_o, .wb_stb_o, .wb_we_o,
    .wb_ack_i, .wb_err_i
  );

  dbg_crc32 u_crc (
    .tck_i, .rst_i, .en_i(crc_en), .shift_i(crc_shift), .clr_i(crc_clr),
    .bit_i(crc_bit), .crc_o(crc), .serial_o(crc_serial)
  );

  dbg_wb_error_reg u_err_reg (
    .tck_i, .rst_i, .check_i(err_check), .clr_i(err_clr),
    .clr_bit_i(data_register_i[DR_CLR_BIT]), .strobe_i(biu_strobe),
    .addr_i(biu_addr), .rdy_i(biu_rdy), .err_i(biu_err), .err_reg_o(err_reg)
  );

endmodule

// File: tb/tb_clock_gen.sv
// Testbench clock and reset
// 40 ns clock, reset held high for the first 16 cycles
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial clk_o = 1'b0;
  always #20 clk_o = ~clk_o;  // 40 ns period

  initial begin
    rst_o = 1'b1;
    repeat (16) @(posedge clk_o);
    rst_o <= 1'b0;  // Released on a rising edge
  end

endmodule

// File: tb/tb_wb_mem.sv
// Wishbone slave memory model, 256 words
// Random ack delay of 0 to 3 cycles, err instead of ack on one address
`timescale 1ns/10ps

module tb_wb_mem (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  output logic        ack_o,
  output logic        err_o,
  input  logic [31:0] err_adr_i,  // Byte address that fails
  input  logic        err_en_i
);

  logic [31:0] mem [256];
  logic        busy_q;     // Access seen, delay running
  logic [1:0]  wait_q;
  logic [7:0]  idx;

  assign idx = adr_i[9:2];  // Word index

  // Fill depends on the whole index
  initial begin
    for (int i = 0; i < 256; i++) mem[i] = 32'h9E37_79B9 * (i + 1);
  end

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_o  <= 1'b0;
      err_o  <= 1'b0;
      busy_q <= 1'b0;
      wait_q <= '0;
      dat_o  <= '0;
    end else begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o && !err_o) begin
        if (!busy_q) begin
          busy_q <= 1'b1;
          wait_q <= 2'($urandom_range(3, 0));  // Stretch the access
        end else if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          busy_q <= 1'b0;
          if (err_en_i && adr_i == err_adr_i) begin
            err_o <= 1'b1;  // Memory left untouched
          end else begin
            ack_o <= 1'b1;
            if (we_i) mem[idx] <= dat_i;
            else dat_o <= mem[idx];
          end
        end
      end
    end
  end

endmodule

// File: tb/tb_dbg_wb.sv
// Testbench for the JTAG Wishbone debug module
// TAP model, burst writes and reads with reference CRC, bus error register
`timescale 1ns/10ps

module tb_dbg_wb import dbg_wb_pkg::*; ();

  localparam int TEST_CYCLES = 5 * 400;  // Rough upper bound per test
  localparam int WATCHDOG_NS = (16 + TEST_CYCLES) * 40 + 200000;
  localparam int MAX_POLLS   = 50;

  logic            clk, rst;
  logic            tdi, capture_dr, shift_dr, update_dr, module_select;
  logic [DR_W-1:0] dr;  // TAP data register
  logic            tdo, top_inhibit;
  logic [31:0]     wb_adr, wb_dat_w, wb_dat_r, err_adr;
  logic            wb_cyc, wb_stb, wb_we, wb_ack, wb_err, err_en;
  logic [31:0]     wr_words [4];
  logic [31:0]     rd_words [4];
  int              errors, checks, test_errs, seed;

  tb_clock_gen i_clk (.clk_o(clk), .rst_o(rst));

  dbg_wb_module i_dut (
    .tck_i(clk), .rst_i(rst), .tdi_i(tdi), .capture_dr_i(capture_dr),
    .shift_dr_i(shift_dr), .update_dr_i(update_dr), .module_select_i(module_select),
    .data_register_i(dr), .module_tdo_o(tdo), .top_inhibit_o(top_inhibit),
    .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r), .wb_cyc_o(wb_cyc),
    .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_ack_i(wb_ack), .wb_err_i(wb_err)
  );

  tb_wb_mem i_mem (
    .clk_i(clk), .rst_i(rst), .adr_i(wb_adr), .dat_i(wb_dat_w), .dat_o(wb_dat_r),
    .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we), .ack_o(wb_ack), .err_o(wb_err),
    .err_adr_i(err_adr), .err_en_i(err_en)
  );

  // TAP data register, tdi enters at the top
  always @(posedge clk or posedge rst) begin
    if (rst) dr <= '0;
    else if (shift_dr) dr <= {tdi, dr[DR_W-1:1]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference CRC and checking
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic d);
    logic [31:0] n;
    n = c >> 1;
    if (d ^ c[0]) n = n ^ CRC_POLY;
    return n;
  endfunction

  function automatic logic [DR_W-1:0] make_cmd(input logic [3:0] op,
                                                input logic [31:0] addr,
                                                input logic [15:0] count);
    return {1'b0, op, addr, count};  // Flag 0 selects this module
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    assert (got == exp) else begin
      $display("Fail at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == test_errs) $display("Test %0d %s: ok", num, name);
    else $display("Test %0d %s: %0d errors", num, name, errors - test_errs);
    test_errs = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // TAP strobes
  task automatic shift_bit(input logic v, output logic t);
    @(posedge clk);
    shift_dr <= 1'b1;
    tdi      <= v;
    @(negedge clk);
    t = tdo;  // Bit the DUT shows before it shifts
  endtask

  task automatic shift_end();
    @(posedge clk);
    shift_dr <= 1'b0;
    tdi      <= 1'b0;
  endtask

  task automatic pulse_update();
    @(posedge clk) update_dr <= 1'b1;
    @(posedge clk) update_dr <= 1'b0;
  endtask

  task automatic pulse_capture();
    @(posedge clk) capture_dr <= 1'b1;
    @(posedge clk) capture_dr <= 1'b0;
  endtask

  task automatic load_command(input logic [DR_W-1:0] cmd);
    logic t;
    for (int i = 0; i < DR_W; i++) shift_bit(cmd[i], t);
    shift_end();
    pulse_update();
  endtask

  task automatic read_ireg(output logic [32:0] val);
    logic t;
    pulse_capture();
    for (int i = 0; i < 33; i++) begin
      shift_bit(1'b0, t);
      val[i] = t;
    end
    shift_end();
  endtask

  // Start bit, 4 words LSB first, then the CRC, then the match bit
  task automatic write_burst(input logic [31:0] addr, input logic flip, output logic match);
    logic        t;
    logic [31:0] crc;
    load_command(make_cmd(CMD_BWRITE32, addr, 16'd4));
    pulse_capture();
    shift_bit(1'b1, t);
    crc = CRC_INIT;
    for (int w = 0; w < 4; w++) begin
      for (int b = 0; b < 32; b++) begin
        shift_bit(wr_words[w][b], t);
        crc = crc_step(crc, wr_words[w][b]);
      end
    end
    if (flip) crc[5] = ~crc[5];
    for (int b = 0; b < 32; b++) shift_bit(crc[b], t);
    shift_end();
    @(negedge clk);
    match = tdo;  // Cycle after the last CRC bit
    pulse_update();
  endtask

  task automatic read_burst(input logic [31:0] addr, output logic [31:0] crc_got,
                            output logic [31:0] crc_ref);
    logic t;
    int   polls;
    load_command(make_cmd(CMD_BREAD32, addr, 16'd4));
    pulse_capture();
    polls = 0;
    do begin
      shift_bit(1'b0, t);
      check_value(64'(top_inhibit), 64'd1, "top_inhibit_o during ready poll");
      polls++;
    end while (!t && polls < MAX_POLLS);
    if (!t) begin
      $display("Ready bit never came up after %0d polls", polls);
      errors++;
    end
    crc_ref = CRC_INIT;
    for (int w = 0; w < 4; w++) begin
      for (int b = 0; b < 32; b++) begin
        shift_bit(1'b0, t);
        check_value(64'(top_inhibit), 64'd1, "top_inhibit_o during read data");
        rd_words[w][b] = t;
        crc_ref = crc_step(crc_ref, t);
      end
    end
    for (int b = 0; b < 32; b++) begin
      shift_bit(1'b0, t);
      check_value(64'(top_inhibit), 64'd1, "top_inhibit_o during read CRC");
      crc_got[b] = t;
    end
    shift_end();
    pulse_update();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  initial begin
    logic [32:0] ireg;
    logic        match;
    logic [31:0] crc_got, crc_ref, exp_words [4];
    int          base;
    seed = $urandom(48);
    errors = 0;
    checks = 0;
    test_errs = 0;
    tdi <= 1'b0;
    capture_dr <= 1'b0;
    shift_dr <= 1'b0;
    update_dr <= 1'b0;
    module_select <= 1'b0;
    err_adr <= '0;
    err_en <= 1'b0;
    wait (!rst);
    @(posedge clk) module_select <= 1'b1;

    read_ireg(ireg);  // Error register after reset
    check_value(64'(ireg), 64'd0, "error register after reset");
    check_value(64'(top_inhibit), 64'd0, "top_inhibit_o when idle");
    check_value(64'({wb_cyc, wb_stb, wb_we}), 64'd0, "Wishbone cyc, stb and we when idle");
    end_test(1, "reset state");

    base = $urandom % 252;
    for (int w = 0; w < 4; w++) wr_words[w] = $urandom;
    write_burst(32'(base * 4), 1'b0, match);
    check_value(64'(match), 64'd1, "match bit with good CRC");
    for (int w = 0; w < 4; w++) begin
      check_value(64'(i_mem.mem[base + w]), 64'(wr_words[w]), "memory word after write");
    end
    end_test(2, "burst write");

    write_burst(32'(base * 4), 1'b1, match);
    check_value(64'(match), 64'd0, "match bit with bad CRC");
    end_test(3, "write CRC mismatch");

    base = $urandom % 252;
    for (int w = 0; w < 4; w++) exp_words[w] = i_mem.mem[base + w];
    read_burst(32'(base * 4), crc_got, crc_ref);
    for (int w = 0; w < 4; w++) begin
      check_value(64'(rd_words[w]), 64'(exp_words[w]), "read data word");
    end
    check_value(64'(crc_got), 64'(crc_ref), "read CRC");
    end_test(4, "burst read");

    // Third word of the burst answers with err
    base = $urandom % 252;
    @(posedge clk);
    err_adr <= 32'((base + 2) * 4);
    err_en  <= 1'b1;
    for (int w = 0; w < 4; w++) wr_words[w] = $urandom;
    write_burst(32'(base * 4), 1'b0, match);
    read_ireg(ireg);
    check_value(64'(ireg[0]), 64'd1, "error flag after bus error");
    check_value(64'(ireg[32:1]), 64'((base + 2) * 4), "trapped error address");
    @(posedge clk) err_en <= 1'b0;
    load_command(make_cmd(CMD_IREG_WR, 32'h4000_0000, 16'd0));  // Bit 46 set
    read_ireg(ireg);
    check_value(64'(ireg[0]), 64'd0, "error flag after clear");
    end_test(5, "bus error register");

    $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: project.f
verilog/dbg_wb_pkg.sv
verilog/dbg_crc32.sv
verilog/dbg_wb_master.sv
verilog/dbg_wb_error_reg.sv
verilog/dbg_wb_ctrl.sv
verilog/dbg_wb_module.sv
tb/tb_clock_gen.sv
tb/tb_wb_mem.sv
tb/tb_dbg_wb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the debug module testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_dbg_wb -o sim_dbg_wb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_dbg_wb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
  exit 0
fi
exit 1
